//--- flist.f
hdl/memMapPkg.sv
hdl/addrDecode.sv
hdl/anticRegs.sv
hdl/gtiaRegs.sv
hdl/pokeyRegs.sv
hdl/readSelect.sv
hdl/memoryMap.sv
tb/memoryMap_properties.sv
tb/memoryMapTb.sv

//--- hdl/addrDecode.sv
`timescale 1ns/1ns
// Zero-latency decode; register banks only exist in the C000h..F7FFh gap
module addrDecode import memMapPkg::*; (
  input  logic [AddrW-1:0] cpuAddr,
  input  logic [DataW-1:0] cpuDataIn,
  input  logic             cpuWriteEn,
  output busReqT           busReq,
  output logic             ramWrite,
  output regionT           region
);

  regionT rgn;
  bankT   bank;

  // Memory regions
  always_comb begin
    if (cpuAddr < RamTop) rgn = regionRam;
    else if (cpuAddr < CartTop) rgn = regionCart;
    else if (cpuAddr >= BiosBase) rgn = regionBios;
    else rgn = regionNone;  // Register space
  end

  // Bank pages, compared on the bits above each bank's size
  always_comb begin
    bank = bankNone;
    if (rgn == regionNone) begin
      if (cpuAddr[AddrW-1:5] == GtiaBase[AddrW-1:5]) bank = bankGtia;
      else if (cpuAddr[AddrW-1:4] == AnticBase[AddrW-1:4]) bank = bankAntic;
      else if (cpuAddr[AddrW-1:4] == PokeyBase[AddrW-1:4]) bank = bankPokey;
    end
  end

  assign region   = rgn;
  assign ramWrite = cpuWriteEn && (rgn == regionRam);  // Never outside RAM

  always_comb begin
    busReq.region   = rgn;
    busReq.bank     = bank;
    busReq.offset   = (bank == bankNone) ? 5'd0 : cpuAddr[4:0];  // Bit 4 is zero for 16-entry banks
    busReq.regWrite = cpuWriteEn && (bank != bankNone);
    busReq.data     = cpuDataIn;
  end

endmodule

//--- hdl/anticRegs.sv
`timescale 1ns/1ns
// CPU writes land on the next edge; a side-load touching the written register is dropped whole
// Offsets Bh..Dh are read-only here, writes to them are ignored
module anticRegs import memMapPkg::*; (
  input  logic             Fclk,
  input  logic             rst,
  input  busReqT           busReq,
  input  anticLoadT        anticLoad,
  input  logic [DataW-1:0] dlistLIn,
  input  logic [DataW-1:0] dlistHIn,
  input  logic [DataW-1:0] nmistIn,
  input  logic [DataW-1:0] vcountIn,
  output anticRegsT        regs,
  output logic [DataW-1:0] vcount
);

  logic cpuWr;
  logic loadL;     // Display list low byte
  logic loadH;     // Display list high byte
  logic loadN;     // NMI status
  logic conflict;

  assign cpuWr = busReq.regWrite && (busReq.bank == bankAntic);

  // Load code to target set
  always_comb begin
    loadL = 1'b0;
    loadH = 1'b0;
    loadN = 1'b0;
    case (anticLoad)
      loadListLow:     loadL = 1'b1;
      loadListBoth:    {loadL, loadH} = 2'b11;
      loadListLowNmi:  {loadL, loadN} = 2'b11;
      loadListBothNmi: {loadL, loadH, loadN} = 3'b111;
      loadNmiOnly:     loadN = 1'b1;
      default:         ;
    endcase
  end

  // CPU hits any register the load would write
  assign conflict = cpuWr && ((loadL && (busReq.offset == OffDlistL)) ||
                              (loadH && (busReq.offset == OffDlistH)) ||
                              (loadN && (busReq.offset == OffNmist)));

  always_ff @(posedge Fclk or posedge rst) begin
    if (rst) begin
      regs   <= '0;
      vcount <= '0;
    end else begin
      vcount <= vcountIn;  // Captured every cycle
      if (cpuWr) begin
        case (busReq.offset)
          5'h00:     regs.dmaCtl  <= busReq.data;
          5'h01:     regs.chrCtl  <= busReq.data;
          OffDlistL: regs.dlistL  <= busReq.data;
          OffDlistH: regs.dlistH  <= busReq.data;
          5'h04:     regs.hScroll <= busReq.data;
          5'h05:     regs.vScroll <= busReq.data;
          5'h07:     regs.pmBase  <= busReq.data;
          5'h09:     regs.chBase  <= busReq.data;
          5'h0A:     regs.wsync   <= busReq.data;
          5'h0E:     regs.nmiEn   <= busReq.data;
          OffNmist:  regs.nmiSt   <= busReq.data;
          default:   ;
        endcase
      end
      // Targets are disjoint from the CPU register when no conflict
      if (!conflict) begin
        if (loadL) regs.dlistL <= dlistLIn;
        if (loadH) regs.dlistH <= dlistHIn;
        if (loadN) regs.nmiSt  <= nmistIn;
      end
    end
  end

endmodule

//--- hdl/gtiaRegs.sv
`timescale 1ns/1ns
// Position, size, graphics, color and control registers, indexed straight by bank offset
module gtiaRegs import memMapPkg::*; (
  input  logic                        Fclk,
  input  logic                        rst,
  input  busReqT                      busReq,
  output logic [GtiaN-1:0][DataW-1:0] regs
);

  logic cpuWr;

  assign cpuWr = busReq.regWrite && (busReq.bank == bankGtia);

  // 00h..07h HPOS, 08h..0Ch SIZE, 0Dh..11h GRAF
  // 12h..1Ah colors, 1Bh..1Fh PRIOR VDELAY GRACTL HITCLR CONSPK
  always_ff @(posedge Fclk or posedge rst) begin
    if (rst) begin
      regs <= '0;
    end else if (cpuWr) begin
      regs[busReq.offset] <= busReq.data;  // Full 5-bit offset, all 32 writable
    end
  end

endmodule

//--- hdl/memMapPkg.sv
// Shared widths, map constants and bus types for the memory-map block
// Bank bases must stay aligned to their bank size, decode compares upper bits only
package memMapPkg;

  localparam int DataW = 8;   // CPU data bus
  localparam int AddrW = 16;  // CPU address bus

  localparam int GtiaN     = 32;  // GTIA write registers
  localparam int PokeyN    = 16;  // POKEY write registers and status bytes
  localparam int GtiaStatN = 22;  // 16 collision, 4 trigger, PAL, console

  // Region boundaries
  localparam logic [AddrW-1:0] RamTop   = 16'h4000;  // RAM is below this
  localparam logic [AddrW-1:0] CartTop  = 16'hC000;  // Cartridge 4000h..BFFFh
  localparam logic [AddrW-1:0] BiosBase = 16'hF800;  // BIOS to top of space

  // Register bank pages, inside the unmapped gap
  localparam logic [AddrW-1:0] AnticBase = 16'hD400;  // 16 entries
  localparam logic [AddrW-1:0] GtiaBase  = 16'hC000;  // 32 entries
  localparam logic [AddrW-1:0] PokeyBase = 16'hE800;  // 16 entries

  // Named offsets within a bank
  localparam logic [4:0] OffDlistL       = 5'h02;
  localparam logic [4:0] OffDlistH       = 5'h03;
  localparam logic [4:0] OffNmist        = 5'h0F;
  localparam logic [4:0] OffStimer       = 5'h09;
  localparam logic [4:0] OffPotgo        = 5'h0B;
  localparam logic [4:0] OffGtiaRegFirst = 5'h15;  // COLPM3, first GTIA reg readback
  localparam logic [4:0] OffGtiaRegLast  = 5'h1E;  // HITCLR, last one

  typedef enum logic [1:0] {regionNone, regionRam, regionCart, regionBios} regionT;

  typedef enum logic [1:0] {bankNone, bankAntic, bankGtia, bankPokey} bankT;

  // Video-side load codes, code 3 unused
  typedef enum logic [2:0] {
    loadNone        = 3'd0,
    loadListLow     = 3'd1,
    loadListBoth    = 3'd2,
    loadListLowNmi  = 3'd4,
    loadListBothNmi = 3'd5,
    loadNmiOnly     = 3'd6
  } anticLoadT;

  typedef struct packed {
    regionT           region;
    bankT             bank;
    logic [4:0]       offset;    // Zero outside the banks
    logic             regWrite;  // CPU write that hits a bank
    logic [DataW-1:0] data;
  } busReqT;

  typedef struct packed {
    logic [DataW-1:0] dmaCtl;
    logic [DataW-1:0] chrCtl;
    logic [DataW-1:0] dlistL;
    logic [DataW-1:0] dlistH;
    logic [DataW-1:0] hScroll;
    logic [DataW-1:0] vScroll;
    logic [DataW-1:0] pmBase;
    logic [DataW-1:0] chBase;
    logic [DataW-1:0] wsync;
    logic [DataW-1:0] nmiEn;
    logic [DataW-1:0] nmiSt;
  } anticRegsT;

  typedef struct packed {
    logic [DataW-1:0] vcount;
    logic [DataW-1:0] penH;
    logic [DataW-1:0] penV;
  } anticStatusT;

endpackage

//--- hdl/memoryMap.sv
`timescale 1ns/1ns
// Memory map top; reads are combinational, register writes land on the next Fclk edge
// RAM and BIOS sit outside, their data come in and the RAM write enable goes out
module memoryMap import memMapPkg::*; #(
  parameter int StrobeWidth = 8
) (
  input  logic                          Fclk,
  input  logic                          rst,
  input  logic [AddrW-1:0]              cpuAddr,
  input  logic [DataW-1:0]              cpuDataIn,
  input  logic                          cpuWriteEn,
  input  logic [DataW-1:0]              ramData,
  input  logic [DataW-1:0]              biosData,
  input  logic [DataW-1:0]              cartData,
  input  anticLoadT                     anticLoad,
  input  logic [DataW-1:0]              dlistLIn,
  input  logic [DataW-1:0]              dlistHIn,
  input  logic [DataW-1:0]              nmistIn,
  input  anticStatusT                   anticStatus,
  input  logic [GtiaStatN-1:0][DataW-1:0] gtiaStatus,
  input  logic [PokeyN-1:0][DataW-1:0]  pokeyStatus,
  output logic [DataW-1:0]              cpuDataOut,
  output logic                          ramWrite,
  output regionT                        region,
  output anticRegsT                     anticRegs,
  output logic [GtiaN-1:0][DataW-1:0]   gtiaRegs,
  output logic [PokeyN-1:0][DataW-1:0]  pokeyRegs,
  output logic                          potgoStrobe,
  output logic                          stimerStrobe
);

  busReqT           busReq;  // Decoded access, shared by all banks
  logic [DataW-1:0] vcount;

  addrDecode uDecode (
    .cpuAddr   (cpuAddr),
    .cpuDataIn (cpuDataIn),
    .cpuWriteEn(cpuWriteEn),
    .busReq    (busReq),
    .ramWrite  (ramWrite),
    .region    (region)
  );

  anticRegs uAntic (
    .Fclk     (Fclk),
    .rst      (rst),
    .busReq   (busReq),
    .anticLoad(anticLoad),
    .dlistLIn (dlistLIn),
    .dlistHIn (dlistHIn),
    .nmistIn  (nmistIn),
    .vcountIn (anticStatus.vcount),  // Live count from the video side
    .regs     (anticRegs),
    .vcount   (vcount)
  );

  gtiaRegs uGtia (
    .Fclk  (Fclk),
    .rst   (rst),
    .busReq(busReq),
    .regs  (gtiaRegs)
  );

  pokeyRegs #(.StrobeWidth(StrobeWidth)) uPokey (
    .Fclk        (Fclk),
    .rst         (rst),
    .busReq      (busReq),
    .regs        (pokeyRegs),
    .potgoStrobe (potgoStrobe),
    .stimerStrobe(stimerStrobe)
  );

  readSelect uRead (
    .busReq     (busReq),
    .ramData    (ramData),
    .biosData   (biosData),
    .cartData   (cartData),
    .anticRegs  (anticRegs),
    .vcount     (vcount),
    .anticStatus(anticStatus),
    .gtiaRegs   (gtiaRegs),
    .gtiaStatus (gtiaStatus),
    .pokeyStatus(pokeyStatus),
    .cpuDataOut (cpuDataOut)
  );

endmodule

//--- hdl/pokeyRegs.sv
`timescale 1ns/1ns
// Strobes rise on the edge after the write and hold StrobeWidth cycles; a rewrite restarts them
module pokeyRegs import memMapPkg::*; #(
  parameter int StrobeWidth = 8
) (
  input  logic                         Fclk,
  input  logic                         rst,
  input  busReqT                       busReq,
  output logic [PokeyN-1:0][DataW-1:0] regs,
  output logic                         potgoStrobe,
  output logic                         stimerStrobe
);

  localparam int CntW = $clog2(StrobeWidth + 1);

  logic                 cpuWr;
  logic [1:0]           fire;  // Bit 0 POTGO, bit 1 STIMER
  logic [1:0][CntW-1:0] cnt;   // Cycles of strobe left

  assign cpuWr   = busReq.regWrite && (busReq.bank == bankPokey);
  assign fire[0] = cpuWr && (busReq.offset == OffPotgo);
  assign fire[1] = cpuWr && (busReq.offset == OffStimer);

  // AUDF/AUDC pairs, AUDCTL, STIMER, SKREST, POTGO, SEROUT, IRQEN, SKCTL
  always_ff @(posedge Fclk or posedge rst) begin
    if (rst) begin
      regs <= '0;
    end else if (cpuWr) begin
      regs[busReq.offset[3:0]] <= busReq.data;
    end
  end

  // Down-counters, loaded on write
  always_ff @(posedge Fclk or posedge rst) begin
    if (rst) begin
      cnt <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (fire[i]) begin
          cnt[i] <= CntW'(StrobeWidth);
        end else if (cnt[i] != '0) begin
          cnt[i] <= cnt[i] - CntW'(1);
        end
      end
    end
  end

  assign potgoStrobe  = (cnt[0] != '0);
  assign stimerStrobe = (cnt[1] != '0);  // High while count runs

endmodule

//--- hdl/readSelect.sv
`timescale 1ns/1ns
// Combinational read mux; unmapped addresses and write-only holes read as zero
module readSelect import memMapPkg::*; (
  input  busReqT                          busReq,
  input  logic [DataW-1:0]                ramData,
  input  logic [DataW-1:0]                biosData,
  input  logic [DataW-1:0]                cartData,
  input  anticRegsT                       anticRegs,
  input  logic [DataW-1:0]                vcount,
  input  anticStatusT                     anticStatus,
  input  logic [GtiaN-1:0][DataW-1:0]     gtiaRegs,
  input  logic [GtiaStatN-1:0][DataW-1:0] gtiaStatus,
  input  logic [PokeyN-1:0][DataW-1:0]    pokeyStatus,
  output logic [DataW-1:0]                cpuDataOut
);

  logic [DataW-1:0] anticRd;
  logic [DataW-1:0] gtiaRd;

  always_comb begin
    case (busReq.offset[3:0])
      4'h0: anticRd = anticRegs.dmaCtl;
      4'h1: anticRd = anticRegs.chrCtl;
      4'h2: anticRd = anticRegs.dlistL;
      4'h3: anticRd = anticRegs.dlistH;
      4'h4: anticRd = anticRegs.hScroll;
      4'h5: anticRd = anticRegs.vScroll;
      4'h7: anticRd = anticRegs.pmBase;
      4'h9: anticRd = anticRegs.chBase;
      4'hA: anticRd = anticRegs.wsync;
      4'hB: anticRd = vcount;            // Registered copy, one cycle late
      4'hC: anticRd = anticStatus.penH;
      4'hD: anticRd = anticStatus.penV;
      4'hE: anticRd = anticRegs.nmiEn;
      4'hF: anticRd = anticRegs.nmiSt;
      default: anticRd = '0;             // 6h and 8h
    endcase
  end

  // Collision, trigger and PAL below the color range, console at the top
  always_comb begin
    if (busReq.offset < OffGtiaRegFirst) gtiaRd = gtiaStatus[busReq.offset];
    else if (busReq.offset <= OffGtiaRegLast) gtiaRd = gtiaRegs[busReq.offset];
    else gtiaRd = gtiaStatus[GtiaStatN-1];
  end

  always_comb begin
    case (busReq.region)
      regionRam:  cpuDataOut = ramData;
      regionCart: cpuDataOut = cartData;
      regionBios: cpuDataOut = biosData;
      default: begin
        case (busReq.bank)
          bankAntic: cpuDataOut = anticRd;
          bankGtia:  cpuDataOut = gtiaRd;
          bankPokey: cpuDataOut = pokeyStatus[busReq.offset[3:0]];
          default:   cpuDataOut = '0;
        endcase
      end
    endcase
  end

endmodule

//--- run.sh
#!/bin/sh
# Builds the memory-map testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module memoryMapTb -f flist.f -o memoryMapSim
./obj_dir/memoryMapSim | tee sim.log
if grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation result: pass"
else
  echo "Simulation result: fail"
  exit 1
fi

//--- tb/memoryMapTb.sv
`timescale 1ns/1ns
// Reads tb/memoryMap_stimulus.txt by a path relative to the project root, so run it from there
// Status bytes are random from a fixed seed, and the run stops at the first mismatch
module memoryMapTb import memMapPkg::*; ();

  localparam int StrobeW       = 8;   // Same width as the stimulus file expects
  localparam int StrobeTimeout = 64;  // Cycles before a strobe wait gives up

  logic                            Fclk;
  logic                            rst;
  logic [AddrW-1:0]                cpuAddr;
  logic [DataW-1:0]                cpuDataIn;
  logic                            cpuWriteEn;
  logic [DataW-1:0]                ramData;
  logic [DataW-1:0]                biosData;
  logic [DataW-1:0]                cartData;
  anticLoadT                       anticLoad;
  logic [DataW-1:0]                dlistLIn;
  logic [DataW-1:0]                dlistHIn;
  logic [DataW-1:0]                nmistIn;
  anticStatusT                     anticStatus;
  logic [GtiaStatN-1:0][DataW-1:0] gtiaStatus;
  logic [PokeyN-1:0][DataW-1:0]    pokeyStatus;
  logic [DataW-1:0]                cpuDataOut;
  logic                            ramWrite;
  regionT                          region;
  anticRegsT                       anticRegs;
  logic [GtiaN-1:0][DataW-1:0]     gtiaRegs;
  logic [PokeyN-1:0][DataW-1:0]    pokeyRegs;
  logic                            potgoStrobe;
  logic                            stimerStrobe;

  // Reference model
  logic [7:0]  anticM [16];      // ANTIC registers by offset
  logic [7:0]  gtiaM [32];       // GTIA write registers
  logic [7:0]  gtiaStatM [22];   // Copies of the driven status bytes
  logic [7:0]  pokeyStatM [16];
  logic [7:0]  penHM;
  logic [7:0]  penVM;
  logic [7:0]  vDrv;             // Count held on the input for many cycles
  logic [31:0] lfsr = 32'h9380;

  memoryMap #(.StrobeWidth(StrobeW)) DUT (.*);

  initial begin
    Fclk = 1'b0;
    forever #2 Fclk = ~Fclk;  // 4 ns period
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [7:0] randByte();
    logic [7:0] b;
    for (int i = 0; i < 8; i++) begin
      b[i] = lfsr[0];
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'hD000_0001 : 32'h0);
    end
    return b;
  endfunction

  task automatic check(input string name, input logic [7:0] expected, input logic [7:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s expected %02h actual %02h", name, expected, actual);
      $display("SOME TESTS FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic failRun(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "Run aborted");
  endtask

  // RAM below 4000h, cartridge up to BFFFh, BIOS from F800h
  function automatic regionT expectRegion(input logic [15:0] a);
    if (a < 16'h4000) return regionRam;
    if (a < 16'hC000) return regionCart;
    if (a >= 16'hF800) return regionBios;
    return regionNone;
  endfunction

  // Readback from the memory map rules: GTIA C000h, ANTIC D400h, POKEY E800h
  function automatic logic [7:0] expectRead(input logic [15:0] a);
    logic [4:0] off;
    off = a[4:0];
    if (a >= 16'hC000 && a <= 16'hC01F) begin
      if (off <= 5'h14) return gtiaStatM[off];  // Collision, trigger, PAL
      if (off <= 5'h1E) return gtiaM[off];
      return gtiaStatM[21];                     // Console
    end
    if (a >= 16'hD400 && a <= 16'hD40F) begin
      case (off[3:0])
        4'h6, 4'h8: return 8'h00;
        4'hB:       return vDrv;
        4'hC:       return penHM;
        4'hD:       return penVM;
        default:    return anticM[off[3:0]];
      endcase
    end
    if (a >= 16'hE800 && a <= 16'hE80F) return pokeyStatM[off[3:0]];
    return 8'h00;  // Unmapped
  endfunction

  // Register output port that a bank address writes
  function automatic logic [7:0] registerOutput(input logic [15:0] a);
    if (a >= 16'hC000 && a <= 16'hC01F) return gtiaRegs[a[4:0]];
    if (a >= 16'hE800 && a <= 16'hE80F) return pokeyRegs[a[3:0]];
    case (a[3:0])
      4'h0:    return anticRegs.dmaCtl;
      4'h1:    return anticRegs.chrCtl;
      4'h2:    return anticRegs.dlistL;
      4'h3:    return anticRegs.dlistH;
      4'h4:    return anticRegs.hScroll;
      4'h5:    return anticRegs.vScroll;
      4'h7:    return anticRegs.pmBase;
      4'h9:    return anticRegs.chBase;
      4'hA:    return anticRegs.wsync;
      4'hE:    return anticRegs.nmiEn;
      4'hF:    return anticRegs.nmiSt;
      default: return 8'h00;
    endcase
  endfunction

  function automatic void modelWrite(input logic [15:0] a, input logic [7:0] d);
    if (a >= 16'hC000 && a <= 16'hC01F) gtiaM[a[4:0]] = d;
    else if (a >= 16'hD400 && a <= 16'hD40F && !(a[3:0] inside {4'h6, 4'h8, 4'hB, 4'hC, 4'hD}))
      anticM[a[3:0]] = d;  // Read-only and hole offsets keep nothing
  endfunction

  // Bits are NMI status, list high, list low
  function automatic logic [2:0] loadTargets(input logic [2:0] code);
    case (code)
      3'd1:    return 3'b001;
      3'd2:    return 3'b011;
      3'd4:    return 3'b101;
      3'd5:    return 3'b111;
      3'd6:    return 3'b100;
      default: return 3'b000;
    endcase
  endfunction

  function automatic void applyLoads(input logic [2:0] tgt, input logic [7:0] l,
                                     input logic [7:0] h, input logic [7:0] n);
    if (tgt[0]) anticM[2] = l;
    if (tgt[1]) anticM[3] = h;
    if (tgt[2]) anticM[15] = n;
  endfunction

  function automatic logic strobeOf(input logic [15:0] a);
    return (a[3:0] == 4'hB) ? potgoStrobe : stimerStrobe;  // POTGO at Bh, STIMER at 9h
  endfunction

  task automatic busIdle();
    cpuWriteEn = 1'b0;
    anticLoad  = loadNone;
  endtask

  task automatic checkListRegs(input string name);
    check({name, " dlistL"}, anticM[2], anticRegs.dlistL);
    check({name, " dlistH"}, anticM[3], anticRegs.dlistH);
    check({name, " nmiSt"}, anticM[15], anticRegs.nmiSt);
  endtask

  // One stimulus line, started and finished on a falling edge
  task automatic runCommand(input logic [7:0] cmd, input logic [15:0] a,
                            input logic [7:0] d, input logic [7:0] e);
    string      name;
    logic [2:0] tgt;
    logic       hit;
    int         waited;
    int         width;
    name = $sformatf("%c %04h", cmd, a);
    case (cmd)
      "M": begin
        cpuAddr  = a;
        ramData  = d;
        cartData = d ^ 8'h0F;  // Distinct per source
        biosData = d ^ 8'hF0;
        #1;
        check(name, e, cpuDataOut);
        check({name, " region"}, 8'(expectRegion(a)), 8'(region));
      end
      "P": begin
        cpuAddr    = a;
        cpuDataIn  = d;
        cpuWriteEn = 1'b1;
        #1;
        check(name, e, 8'(ramWrite));
        busIdle();
      end
      "W": begin
        cpuAddr    = a;
        cpuDataIn  = d;
        cpuWriteEn = 1'b1;
        modelWrite(a, d);
        @(negedge Fclk);
        busIdle();
        #1;
        check({name, " reg"}, e, registerOutput(a));
        check({name, " read"}, expectRead(a), cpuDataOut);
      end
      "R": begin
        cpuAddr = a;
        #1;
        check(name, expectRead(a), cpuDataOut);
      end
      "V": begin
        anticStatus.vcount = d;
        @(negedge Fclk);
        anticStatus.vcount = ~d;  // Readback must still show the old count
        cpuAddr = a;
        #1;
        check(name, e, cpuDataOut);
        vDrv = ~d;
      end
      "L": begin
        anticLoad = anticLoadT'(a[2:0]);
        dlistLIn  = d;
        dlistHIn  = d + 8'h11;
        nmistIn   = d + 8'h22;
        applyLoads(loadTargets(a[2:0]), d, d + 8'h11, d + 8'h22);
        @(negedge Fclk);
        busIdle();
        #1;
        checkListRegs(name);
      end
      "C": begin
        cpuAddr    = a;
        cpuDataIn  = d;
        cpuWriteEn = 1'b1;
        anticLoad  = anticLoadT'(e[2:0]);
        dlistLIn   = ~d;
        dlistHIn   = ~d + 8'd1;
        nmistIn    = ~d + 8'd2;
        tgt = loadTargets(e[2:0]);
        hit = (tgt[0] && a[3:0] == 4'h2) || (tgt[1] && a[3:0] == 4'h3) ||
              (tgt[2] && a[3:0] == 4'hF);
        modelWrite(a, d);
        if (!hit) applyLoads(tgt, ~d, ~d + 8'd1, ~d + 8'd2);  // Load dropped whole on a hit
        @(negedge Fclk);
        busIdle();
        #1;
        checkListRegs(name);
        check({name, " cpu"}, anticM[a[3:0]], registerOutput(a));
      end
      "S": begin
        cpuAddr    = a;
        cpuDataIn  = d;
        cpuWriteEn = 1'b1;
        @(negedge Fclk);
        busIdle();
        waited = 0;
        while (!strobeOf(a) && waited < StrobeTimeout) begin
          waited++;
          @(negedge Fclk);
        end
        if (!strobeOf(a)) failRun($sformatf("Strobe for %04h never rose after the write", a));
        width = 0;
        while (strobeOf(a)) begin
          if (width == StrobeTimeout) failRun($sformatf("Strobe for %04h stayed high", a));
          width++;
          @(negedge Fclk);
        end
        check(name, e, 8'(width));
      end
      default: failRun($sformatf("Unknown command %c in the stimulus file", cmd));
    endcase
    @(negedge Fclk);
  endtask

  initial begin
    int         fd;
    int         n;
    string      line;
    logic [7:0] cmd;
    logic [15:0] a;
    logic [7:0] d;
    logic [7:0] e;
    rst        = 1'b1;
    cpuAddr    = '0;
    cpuDataIn  = '0;
    cpuWriteEn = 1'b0;
    ramData    = '0;
    biosData   = '0;
    cartData   = '0;
    anticLoad  = loadNone;
    dlistLIn   = '0;
    dlistHIn   = '0;
    nmistIn    = '0;
    for (int i = 0; i < 16; i++) anticM[i] = '0;
    for (int i = 0; i < 32; i++) gtiaM[i] = '0;
    for (int i = 0; i < 22; i++) begin
      gtiaStatM[i]  = randByte();
      gtiaStatus[i] = gtiaStatM[i];
    end
    for (int i = 0; i < 16; i++) begin
      pokeyStatM[i]  = randByte();
      pokeyStatus[i] = pokeyStatM[i];
    end
    penHM = randByte();
    penVM = randByte();
    vDrv  = randByte();
    anticStatus = '{vcount: vDrv, penH: penHM, penV: penVM};
    repeat (3) @(posedge Fclk);
    @(negedge Fclk);
    check("reset antic", 8'h00, 8'(anticRegs != '0));
    check("reset gtia", 8'h00, 8'(gtiaRegs != '0));
    check("reset pokey", 8'h00, 8'(pokeyRegs != '0));
    check("reset strobes", 8'h00, 8'({potgoStrobe, stimerStrobe}));
    check("reset ramWrite", 8'h00, 8'(ramWrite));
    rst = 1'b0;
    @(negedge Fclk);
    fd = $fopen("tb/memoryMap_stimulus.txt", "r");
    if (fd == 0) failRun("Could not open tb/memoryMap_stimulus.txt");
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%c %h %h %h", cmd, a, d, e);
      if (n == 4 && cmd != "#") runCommand(cmd, a, d, e);  // Skips comments and blanks
    end
    $fclose(fd);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- tb/memoryMap_properties.sv
`timescale 1ns/1ns
// Bound into memoryMap; decode checks compare against the raw CPU address
// Strobe checks assume one writer per strobe and sample on the rising Fclk edge
module memoryMap_properties import memMapPkg::*; #(
  parameter int StrobeWidth = 8
) (
  input logic             Fclk,
  input logic             rst,
  input logic [AddrW-1:0] cpuAddr,
  input busReqT           busReq,
  input logic             ramWrite,
  input logic             potgoStrobe,
  input logic             stimerStrobe
);

  localparam int CntW = $clog2(StrobeWidth + 2);  // Saturation value stays above the width

  logic [1:0]           wr;       // Bit 0 POTGO, bit 1 STIMER
  logic [1:0]           strobe;
  logic [1:0][CntW-1:0] sinceWr;  // Edges since the last write, saturating

  assign wr[0]  = busReq.regWrite && busReq.bank == bankPokey && busReq.offset == OffPotgo;
  assign wr[1]  = busReq.regWrite && busReq.bank == bankPokey && busReq.offset == OffStimer;
  assign strobe = {stimerStrobe, potgoStrobe};

  always_ff @(posedge Fclk or posedge rst) begin
    if (rst) begin
      sinceWr <= '1;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (wr[i]) sinceWr[i] <= '0;
        else if (sinceWr[i] != '1) sinceWr[i] <= sinceWr[i] + CntW'(1);
      end
    end
  end

  // Exactly one region flag, the one the address falls in; banks only in the gap
  regionOneHot: assert property (@(posedge Fclk) disable iff (rst)
    $onehot({cpuAddr < 16'h4000 && busReq.region == regionRam && busReq.bank == bankNone,
             cpuAddr inside {[16'h4000:16'hBFFF]} && busReq.region == regionCart &&
               busReq.bank == bankNone,
             cpuAddr >= 16'hF800 && busReq.region == regionBios && busReq.bank == bankNone,
             cpuAddr inside {[16'hC000:16'hF7FF]} && busReq.region == regionNone}))
    else $error("Region decode disagrees with address %04h", cpuAddr);

  ramWriteInRam: assert property (@(posedge Fclk) disable iff (rst)
    ramWrite |-> cpuAddr < 16'h4000)
    else $error("RAM write enable at address %04h outside RAM", cpuAddr);

  for (genvar i = 0; i < 2; i++) begin : gStrobe
    riseAfterWrite: assert property (@(posedge Fclk) disable iff (rst)
      $rose(strobe[i]) |-> sinceWr[i] == '0)
      else $error("Strobe %0d rose without a write on the edge before", i);
    fallAfterWidth: assert property (@(posedge Fclk) disable iff (rst)
      $fell(strobe[i]) |-> sinceWr[i] == CntW'(StrobeWidth))
      else $error("Strobe %0d fell %0d edges after its write", i, sinceWr[i]);
  end

endmodule

bind memoryMap memoryMap_properties #(.StrobeWidth(StrobeWidth)) uProps (
  .Fclk        (Fclk),
  .rst         (rst),
  .cpuAddr     (cpuAddr),
  .busReq      (busReq),
  .ramWrite    (ramWrite),
  .potgoStrobe (potgoStrobe),
  .stimerStrobe(stimerStrobe)
);

//--- tb/memoryMap_stimulus.txt
# cmd addr data exp, hex; M read (cart = data^0F, bios = data^F0), P ramWrite probe, W register write
# R status read, V count, L load (addr = code), C write plus load (exp = code), S strobe (exp = width)
M 0000 3c 3c
M 3fff a5 a5
M 4000 3c 33
M bfff a5 aa
M f800 3c cc
M ffff a5 55
M c800 3c 00
M d410 3c 00
M f000 a5 00
P 1234 77 01
P 3fff 77 01
P 4000 77 00
P f900 77 00
W d400 21 21
W d402 40 40
W d403 9c 9c
W d40e c0 c0
W c012 46 46
W c016 88 88
W c01e 5a 5a
W c01f 08 08
W e800 10 10
W e80e 40 40
R c000 00 00
R c00f 00 00
R c013 00 00
R c014 00 00
R c01f 00 00
R e800 00 00
R e80d 00 00
R d40c 00 00
R d40d 00 00
R d406 00 00
R d408 00 00
V d40b 5e 5e
L 0001 11 00
L 0002 22 00
L 0004 33 00
L 0005 44 00
L 0006 55 00
L 0000 66 00
C d402 a1 01
C d40f b2 05
C d400 c3 02
S e80b 01 08
S e809 02 08
